/* Makefile */
# Verilator flow for the SPC7110 decompression unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module tb_spc7110_dcu

# The run passes only when the pass line shows up in the output
sim:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module tb_spc7110_dcu
	@out="$$(./obj_dir/Vtb_spc7110_dcu 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

/* compile.f */
+incdir+.
spc7110_pkg.sv
dcu_ifs.sv
dcu_input_window.sv
dcu_context_store.sv
dcu_arith_decoder.sv
dcu_output_packer.sv
spc7110_dcu.sv
tb_spc7110_dcu.sv

/* dcu_arith_decoder.sv */
`timescale 1ns/1ps

module dcu_arith_decoder #(
    parameter int CTX_BITS = 3
) (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                dcu_init,
    window_if.dec               win,
    context_if.dec              ctx,
    input  logic [CTX_BITS-1:0] history,
    output logic                bit_valid,
    output logic                bit_val,
    input  logic                bit_ready
);
    import spc7110_pkg::*;

    dcu_state_t         state_q;
    logic [RANGE_W-1:0] range_q;
    logic               mps_q;
    logic               bit_q;

    evo_entry_t         evo;
    logic [RANGE_W-1:0] off;
    logic [RANGE_W-1:0] range_next;
    logic [RANGE_W-1:0] range_dbl;
    logic               sym_mps;

    ////////////////////////////////////////////////////////////////////////////
    // Symbol decision
    ////////////////////////////////////////////////////////////////////////////
    assign evo        = EVO_TABLE[ctx.model];
    assign off        = range_q - {1'b0, evo.prob};
    assign sym_mps    = ({1'b0, win.top} < off);
    assign range_next = sym_mps ? off : {1'b0, evo.prob};
    assign range_dbl  = range_q << 1;

    // Restart goes straight to the window and the store
    assign win.start = dcu_init;
    assign ctx.clear = dcu_init;

    // LPS takes the upper part of the interval
    assign win.sub_en  = (state_q == DECODE) && !sym_mps;
    assign win.sub_val = off[ROM_BYTE_W-1:0];
    assign win.shift_en = (state_q == RENORM) && win.ready;

    // Context follows the decoded history
    assign ctx.ctx_idx   = history;
    assign ctx.upd_en    = win.shift_en && (range_dbl >= RANGE_HALF);
    assign ctx.upd_model = mps_q ? evo.next_mps : evo.next_lps;
    assign ctx.upd_swap  = ctx.swap ^ (!mps_q && evo.invert);

    assign bit_valid = (state_q == EMIT);
    assign bit_val   = bit_q;

    ////////////////////////////////////////////////////////////////////////////
    // Decode and renormalize FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            range_q <= RANGE_INIT;
        end else if (dcu_init) begin
            state_q <= PREREAD;
            range_q <= RANGE_INIT;
        end else begin
            case (state_q)
                PREREAD: begin
                    if (win.ready) begin
                        state_q <= DECODE;
                    end
                end
                DECODE: begin
                    range_q <= range_next;
                    state_q <= (range_next < RANGE_HALF) ? RENORM : EMIT;
                end
                RENORM: begin
                    if (!win.ready) begin
                        state_q <= FETCH;
                    end else begin
                        range_q <= range_dbl;
                        if (range_dbl >= RANGE_HALF) begin
                            state_q <= EMIT;
                        end
                    end
                end
                FETCH: begin
                    // Resume whichever step was waiting on the byte
                    if (win.ready) begin
                        state_q <= (range_q < RANGE_HALF) ? RENORM : DECODE;
                    end
                end
                EMIT: begin
                    if (bit_ready) begin
                        state_q <= win.ready ? DECODE : FETCH;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Symbol kind and output bit of the bit in flight
    always_ff @(posedge CLK) begin
        if (state_q == DECODE) begin
            mps_q <= sym_mps;
            bit_q <= ctx.swap ^ !sym_mps;
        end
    end

    a_range_norm_on_decode: assert property (
        @(posedge CLK) disable iff (!rst_n)
        (state_q == DECODE) |-> (range_q >= RANGE_HALF)
    );

endmodule

/* dcu_context_store.sv */
`timescale 1ns/1ps

module dcu_context_store #(
    parameter int CTX_BITS = 3
) (
    input  logic     CLK,
    input  logic     rst_n,
    context_if.store ctx
);
    import spc7110_pkg::*;

    localparam int CTX_COUNT = 2 ** CTX_BITS;

    logic [MODEL_W-1:0] model_q [CTX_COUNT];
    logic               swap_q  [CTX_COUNT];

    // Combinational read for the current history
    assign ctx.model = model_q[ctx.ctx_idx];
    assign ctx.swap  = swap_q[ctx.ctx_idx];

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < CTX_COUNT; i++) begin
                model_q[i] <= '0;
                swap_q[i]  <= 1'b0;
            end
        end else if (ctx.clear) begin
            // New stream starts every context on model 0
            for (int i = 0; i < CTX_COUNT; i++) begin
                model_q[i] <= '0;
                swap_q[i]  <= 1'b0;
            end
        end else if (ctx.upd_en) begin
            model_q[ctx.ctx_idx] <= ctx.upd_model;
            swap_q[ctx.ctx_idx]  <= ctx.upd_swap;
        end
    end

    a_model_in_table: assert property (
        @(posedge CLK) disable iff (!rst_n)
        ctx.upd_en |-> (ctx.upd_model < MODEL_W'(MODEL_COUNT))
    );

endmodule

/* dcu_ifs.sv */
`timescale 1ns/1ps

// Decoder to input window
interface window_if;
    import spc7110_pkg::*;

    logic [ROM_BYTE_W-1:0] top;
    logic                  ready;
    logic                  sub_en;
    logic [ROM_BYTE_W-1:0] sub_val;
    logic                  shift_en;
    logic                  start;

    modport dec (input top, ready, output sub_en, sub_val, shift_en, start);
    modport win (output top, ready, input sub_en, sub_val, shift_en, start);
endinterface

// Decoder to per-context model store
interface context_if #(
    parameter int CTX_BITS = 3
);
    import spc7110_pkg::*;

    logic [CTX_BITS-1:0] ctx_idx;
    logic [MODEL_W-1:0]  model;
    logic                swap;
    logic                upd_en;
    logic [MODEL_W-1:0]  upd_model;
    logic                upd_swap;
    logic                clear;

    modport dec (
        output ctx_idx, upd_en, upd_model, upd_swap, clear,
        input  model, swap
    );
    modport store (
        input  ctx_idx, upd_en, upd_model, upd_swap, clear,
        output model, swap
    );
endinterface

/* dcu_input_window.sv */
`timescale 1ns/1ps

module dcu_input_window (
    input  logic                              CLK,
    input  logic                              rst_n,
    window_if.win                             win,
    input  logic                              datarom_wait,
    input  logic [spc7110_pkg::ROM_BYTE_W-1:0] datarom_data,
    output logic                              datarom_rd
);
    import spc7110_pkg::*;

    logic [2*ROM_BYTE_W-1:0] window_q;
    logic [2:0]              shift_cnt;
    logic                    pre_second;
    dcu_state_t              wstate;
    logic                    take;

    // ROM hands over a byte on this edge
    assign take = datarom_rd && !datarom_wait;

    assign win.top   = window_q[2*ROM_BYTE_W-1:ROM_BYTE_W];
    assign win.ready = (wstate == DECODE);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            window_q   <= '0;
            shift_cnt  <= '0;
            pre_second <= 1'b0;
            wstate     <= IDLE;
            datarom_rd <= 1'b0;
        end else if (win.start) begin
            window_q   <= '0;
            shift_cnt  <= '0;
            pre_second <= 1'b0;
            wstate     <= PREREAD;
            // A byte handed over now belongs to the old stream
            if (take) begin
                datarom_rd <= 1'b0;
            end
        end else begin
            case (wstate)
                PREREAD: begin
                    if (take) begin
                        window_q   <= {window_q[ROM_BYTE_W-1:0], datarom_data};
                        datarom_rd <= 1'b0;
                        pre_second <= 1'b1;
                        if (pre_second) begin
                            wstate <= DECODE;
                        end
                    end else if (!datarom_rd) begin
                        datarom_rd <= 1'b1;
                    end
                end
                FETCH: begin
                    // Low byte is all zeros after eight shifts
                    if (take) begin
                        window_q[ROM_BYTE_W-1:0] <= datarom_data;
                        datarom_rd <= 1'b0;
                        wstate     <= DECODE;
                    end else if (!datarom_rd) begin
                        datarom_rd <= 1'b1;
                    end
                end
                DECODE: begin
                    if (win.sub_en) begin
                        window_q[2*ROM_BYTE_W-1:ROM_BYTE_W] <= win.top - win.sub_val;
                    end else if (win.shift_en) begin
                        window_q  <= window_q << 1;
                        shift_cnt <= shift_cnt + 3'd1;
                        if (shift_cnt == 3'd7) begin
                            wstate <= FETCH;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Decoder only consumes bits that are really in the window
    a_shift_when_ready: assert property (
        @(posedge CLK) disable iff (!rst_n) win.shift_en |-> win.ready
    );

endmodule

/* dcu_output_packer.sv */
`timescale 1ns/1ps

module dcu_output_packer #(
    parameter int OUT_WIDTH = 32,
    parameter int CTX_BITS  = 3
) (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  logic                 dcu_init,
    input  logic                 bit_valid,
    input  logic                 bit_val,
    output logic                 bit_ready,
    output logic [CTX_BITS-1:0]  history,
    input  logic                 ob_wait,
    output logic                 ob_wr,
    output logic [OUT_WIDTH-1:0] ob_data
);

    localparam int CNT_W = $clog2(OUT_WIDTH);

    logic [OUT_WIDTH-1:0] word_q;
    logic [CNT_W-1:0]     cnt_q;
    logic                 full_q;
    logic [CTX_BITS-1:0]  hist_q;
    logic                 accept;

    assign accept    = bit_valid && bit_ready;
    assign bit_ready = !full_q;
    assign history   = hist_q;

    // Word goes out in the first cycle the buffer allows it
    assign ob_wr   = full_q && !ob_wait;
    assign ob_data = word_q;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q  <= '0;
            full_q <= 1'b0;
            hist_q <= '0;
        end else if (dcu_init) begin
            cnt_q  <= '0;
            full_q <= 1'b0;
            hist_q <= '0;
        end else begin
            if (ob_wr) begin
                full_q <= 1'b0;
            end
            if (accept) begin
                hist_q <= CTX_BITS'({hist_q, bit_val});
                cnt_q  <= cnt_q + 1'b1;
                if (cnt_q == CNT_W'(OUT_WIDTH - 1)) begin
                    cnt_q  <= '0;
                    full_q <= 1'b1;
                end
            end
        end
    end

    // First decoded bit ends up in the MSB
    always_ff @(posedge CLK) begin
        if (accept) begin
            word_q <= OUT_WIDTH'({word_q, bit_val});
        end
    end

    a_no_write_on_wait: assert property (
        @(posedge CLK) disable iff (!rst_n) ob_wr |-> !ob_wait
    );

endmodule

/* spc7110_dcu.sv */
`timescale 1ns/1ps

module spc7110_dcu #(
    parameter int OUT_WIDTH = 32,
    parameter int CTX_BITS  = 3
) (
    input  logic                               CLK,
    input  logic                               rst_n,
    input  logic                               dcu_init,
    // Data ROM
    input  logic                               datarom_wait,
    input  logic [spc7110_pkg::ROM_BYTE_W-1:0] datarom_data,
    output logic                               datarom_rd,
    // Output buffer
    input  logic                               ob_wait,
    output logic                               ob_wr,
    output logic [OUT_WIDTH-1:0]               ob_data
);

    logic                bit_valid;
    logic                bit_val;
    logic                bit_ready;
    logic [CTX_BITS-1:0] history;

    window_if                          u_win_if ();
    context_if #(.CTX_BITS(CTX_BITS))  u_ctx_if ();

    dcu_input_window u_input_window (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .win          (u_win_if.win),
        .datarom_wait (datarom_wait),
        .datarom_data (datarom_data),
        .datarom_rd   (datarom_rd)
    );

    dcu_context_store #(
        .CTX_BITS (CTX_BITS)
    ) u_context_store (
        .CLK   (CLK),
        .rst_n (rst_n),
        .ctx   (u_ctx_if.store)
    );

    dcu_arith_decoder #(
        .CTX_BITS (CTX_BITS)
    ) u_arith_decoder (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .dcu_init  (dcu_init),
        .win       (u_win_if.dec),
        .ctx       (u_ctx_if.dec),
        .history   (history),
        .bit_valid (bit_valid),
        .bit_val   (bit_val),
        .bit_ready (bit_ready)
    );

    dcu_output_packer #(
        .OUT_WIDTH (OUT_WIDTH),
        .CTX_BITS  (CTX_BITS)
    ) u_output_packer (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .dcu_init  (dcu_init),
        .bit_valid (bit_valid),
        .bit_val   (bit_val),
        .bit_ready (bit_ready),
        .history   (history),
        .ob_wait   (ob_wait),
        .ob_wr     (ob_wr),
        .ob_data   (ob_data)
    );

endmodule

/* spc7110_pkg.sv */
package spc7110_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and coder constants
    ////////////////////////////////////////////////////////////////////////////
    localparam int ROM_BYTE_W  = 8;
    localparam int RANGE_W     = 9;
    localparam int MODEL_W     = 6;
    localparam int MODEL_COUNT = 53;

    localparam logic [RANGE_W-1:0] RANGE_INIT = 9'h100;
    // Below this the range is doubled
    localparam logic [RANGE_W-1:0] RANGE_HALF = 9'h080;

    typedef enum logic [2:0] {
        IDLE,
        PREREAD,
        DECODE,
        RENORM,
        FETCH,
        EMIT
    } dcu_state_t;

    typedef struct packed {
        logic [7:0]         prob;
        logic [MODEL_W-1:0] next_lps;
        logic [MODEL_W-1:0] next_mps;
        logic               invert;
    } evo_entry_t;

    ////////////////////////////////////////////////////////////////////////////
    // Probability evolution table
    ////////////////////////////////////////////////////////////////////////////
    // Columns are prob, next on LPS, next on MPS, swap toggle on LPS
    localparam evo_entry_t EVO_TABLE [MODEL_COUNT] = '{
        '{8'h5a, 6'd1,  6'd1,  1'b1},
        '{8'h25, 6'd6,  6'd2,  1'b0},
        '{8'h11, 6'd8,  6'd3,  1'b0},
        '{8'h08, 6'd10, 6'd4,  1'b0},
        '{8'h03, 6'd12, 6'd5,  1'b0},
        '{8'h01, 6'd15, 6'd5,  1'b0},
        // Second ladder
        '{8'h5a, 6'd7,  6'd7,  1'b1},
        '{8'h3f, 6'd19, 6'd8,  1'b0},
        '{8'h2c, 6'd21, 6'd9,  1'b0},
        '{8'h20, 6'd22, 6'd10, 1'b0},
        '{8'h17, 6'd23, 6'd11, 1'b0},
        '{8'h11, 6'd25, 6'd12, 1'b0},
        '{8'h0c, 6'd26, 6'd13, 1'b0},
        '{8'h09, 6'd28, 6'd14, 1'b0},
        '{8'h07, 6'd29, 6'd15, 1'b0},
        '{8'h05, 6'd31, 6'd16, 1'b0},
        '{8'h04, 6'd32, 6'd17, 1'b0},
        '{8'h03, 6'd34, 6'd18, 1'b0},
        '{8'h02, 6'd35, 6'd5,  1'b0},
        // Third ladder
        '{8'h5a, 6'd20, 6'd20, 1'b1},
        '{8'h48, 6'd39, 6'd21, 1'b0},
        '{8'h3a, 6'd40, 6'd22, 1'b0},
        '{8'h2e, 6'd42, 6'd23, 1'b0},
        '{8'h26, 6'd44, 6'd24, 1'b0},
        '{8'h1f, 6'd45, 6'd25, 1'b0},
        '{8'h19, 6'd46, 6'd26, 1'b0},
        '{8'h15, 6'd25, 6'd27, 1'b0},
        '{8'h11, 6'd26, 6'd28, 1'b0},
        '{8'h0e, 6'd26, 6'd29, 1'b0},
        '{8'h0b, 6'd27, 6'd30, 1'b0},
        '{8'h09, 6'd28, 6'd31, 1'b0},
        '{8'h08, 6'd29, 6'd32, 1'b0},
        '{8'h07, 6'd30, 6'd33, 1'b0},
        '{8'h05, 6'd31, 6'd34, 1'b0},
        '{8'h04, 6'd33, 6'd35, 1'b0},
        '{8'h04, 6'd33, 6'd36, 1'b0},
        '{8'h03, 6'd34, 6'd37, 1'b0},
        '{8'h02, 6'd35, 6'd38, 1'b0},
        '{8'h02, 6'd36, 6'd5,  1'b0},
        // Fourth ladder
        '{8'h58, 6'd39, 6'd40, 1'b1},
        '{8'h4d, 6'd47, 6'd41, 1'b0},
        '{8'h43, 6'd48, 6'd42, 1'b0},
        '{8'h3b, 6'd49, 6'd43, 1'b0},
        '{8'h34, 6'd50, 6'd44, 1'b0},
        '{8'h2e, 6'd51, 6'd45, 1'b0},
        '{8'h29, 6'd44, 6'd46, 1'b0},
        '{8'h25, 6'd45, 6'd24, 1'b0},
        // Fifth ladder
        '{8'h56, 6'd47, 6'd48, 1'b1},
        '{8'h4f, 6'd47, 6'd49, 1'b0},
        '{8'h47, 6'd48, 6'd50, 1'b0},
        '{8'h41, 6'd49, 6'd51, 1'b0},
        '{8'h3c, 6'd50, 6'd52, 1'b0},
        '{8'h37, 6'd51, 6'd43, 1'b0}
    };

endpackage

/* tb_dcu_model.svh */
`ifndef TB_DCU_MODEL_SVH
`define TB_DCU_MODEL_SVH

// Compressed stream memory, the address wraps at the top
localparam int ROM_AW    = 11;
localparam int ROM_DEPTH = 2 ** ROM_AW;
localparam int CTX_COUNT = 2 ** CTX_BITS;

logic [ROM_BYTE_W-1:0] rom_mem [ROM_DEPTH];
logic [OUT_WIDTH-1:0]  expect_q [$];

// Byte stream of one row, drawn from the row seed
task automatic fill_rom(input logic [31:0] row_seed);
    integer      s;
    logic [31:0] r;
    s = row_seed;
    for (int i = 0; i < ROM_DEPTH; i++) begin
        r = $random(s);
        rom_mem[i] = r[ROM_BYTE_W-1:0];
    end
endtask

////////////////////////////////////////////////////////////////////////////
// Reference decoder, one bit per loop pass
////////////////////////////////////////////////////////////////////////////
task automatic decode_expected(input int n_words);
    logic [2*ROM_BYTE_W-1:0] win;
    logic [ROM_AW-1:0]       byte_idx;
    int                      shifts;
    int                      nbits;
    logic [RANGE_W-1:0]      rng;
    logic [RANGE_W-1:0]      off;
    logic [MODEL_W-1:0]      model_idx [CTX_COUNT];
    logic                    swap_bit [CTX_COUNT];
    logic [CTX_BITS-1:0]     hist;
    evo_entry_t              e;
    logic                    mps;
    logic                    bitv;
    logic [OUT_WIDTH-1:0]    word;
    expect_q.delete();
    for (int c = 0; c < CTX_COUNT; c++) begin
        model_idx[c] = '0;
        swap_bit[c]  = 1'b0;
    end
    // Two bytes are preread, the first one lands in the top byte
    win      = {rom_mem[0], rom_mem[1]};
    byte_idx = ROM_AW'(2);
    shifts   = 0;
    nbits    = 0;
    rng      = RANGE_INIT;
    hist     = '0;
    word     = '0;
    while (expect_q.size() < n_words) begin
        e   = EVO_TABLE[model_idx[hist]];
        off = rng - {1'b0, e.prob};
        mps = ({1'b0, win[2*ROM_BYTE_W-1:ROM_BYTE_W]} < off);
        if (mps) begin
            rng = off;
        end else begin
            win[2*ROM_BYTE_W-1:ROM_BYTE_W] = win[2*ROM_BYTE_W-1:ROM_BYTE_W] - off[ROM_BYTE_W-1:0];
            rng = {1'b0, e.prob};
        end
        bitv = swap_bit[hist] ^ !mps;
        // Model moves only when the interval had to be doubled
        if (rng < RANGE_HALF) begin
            while (rng < RANGE_HALF) begin
                rng    = rng << 1;
                win    = win << 1;
                shifts = shifts + 1;
                if (shifts == ROM_BYTE_W) begin
                    shifts                 = 0;
                    win[ROM_BYTE_W-1:0]    = rom_mem[byte_idx];
                    byte_idx               = byte_idx + 1'b1;
                end
            end
            if (mps) begin
                model_idx[hist] = e.next_mps;
            end else begin
                model_idx[hist] = e.next_lps;
                swap_bit[hist]  = swap_bit[hist] ^ e.invert;
            end
        end
        word  = {word[OUT_WIDTH-2:0], bitv};
        hist  = CTX_BITS'({hist, bitv});
        nbits = nbits + 1;
        if (nbits == OUT_WIDTH) begin
            expect_q.push_back(word);
            nbits = 0;
        end
    end
endtask

`endif

/* tb_spc7110_dcu.sv */
`timescale 1ns/1ps

module tb_spc7110_dcu;
    import spc7110_pkg::*;

    localparam int OUT_WIDTH     = 32;
    localparam int CTX_BITS      = 3;
    localparam int NUM_ROWS      = 6;
    localparam int PARTIAL_WORDS = 2;
    localparam int WORD_TIMEOUT  = 20000;

    typedef struct packed {
        logic [31:0] seed;
        logic [7:0]  words;
        logic        rom_rand;
        logic        ob_rand;
        logic        mid_init;
    } stim_row_t;

    // Seed, words, random ROM wait, random buffer wait, restart mid stream
    localparam stim_row_t STIM_TABLE [NUM_ROWS] = '{
        '{32'h00000001, 8'd4, 1'b0, 1'b0, 1'b0},
        '{32'h13572468, 8'd6, 1'b1, 1'b0, 1'b0},
        '{32'h2b7e1516, 8'd5, 1'b0, 1'b1, 1'b0},
        '{32'h0f0f3c3c, 8'd6, 1'b1, 1'b1, 1'b0},
        '{32'h7a31c0d2, 8'd5, 1'b1, 1'b1, 1'b1},
        '{32'h00000000, 8'd3, 1'b0, 1'b0, 1'b1}
    };

    logic                  CLK = 1'b0;
    logic                  rst_n;
    logic                  dcu_init;
    logic                  datarom_wait;
    logic [ROM_BYTE_W-1:0] datarom_data;
    logic                  datarom_rd;
    logic                  ob_wait;
    logic                  ob_wr;
    logic [OUT_WIDTH-1:0]  ob_data;

    logic                  rom_wait_rand;
    logic                  ob_wait_rand;
    integer                seed;
    logic [31:0]           rand_word;
    logic [10:0]           rom_idx;
    logic                  take_s;
    logic                  init_s;
    logic                  prev_take;
    int                    span_left;
    logic                  span_level;

    `include "tb_dcu_model.svh"

    spc7110_dcu #(
        .OUT_WIDTH (OUT_WIDTH),
        .CTX_BITS  (CTX_BITS)
    ) u_spc7110_dcu (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .dcu_init     (dcu_init),
        .datarom_wait (datarom_wait),
        .datarom_data (datarom_data),
        .datarom_rd   (datarom_rd),
        .ob_wait      (ob_wait),
        .ob_wr        (ob_wr),
        .ob_data      (ob_data)
    );

    always #10 CLK = ~CLK;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // ROM and buffer responder
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        datarom_wait = 1'b0;
        datarom_data = '0;
        ob_wait      = 1'b0;
        rom_idx      = '0;
        prev_take    = 1'b0;
        span_left    = 0;
        span_level   = 1'b0;
        seed         = 32'h94e0732b;
        forever begin
            // Mid cycle values are the ones the next edge sees
            @(negedge CLK);
            take_s = datarom_rd && !datarom_wait;
            init_s = dcu_init;
            assert (!(prev_take && datarom_rd)) else
                stop_on_error("datarom_rd was still high in the cycle after a byte was taken");
            assert (!(ob_wr && ob_wait)) else
                stop_on_error($sformatf("[ERROR] t=%0t ob_wr expected 0 actual 1", $time));
            @(posedge CLK);
            #2;
            prev_take = take_s;
            if (init_s) begin
                rom_idx = '0;
            end else if (take_s) begin
                rom_idx = rom_idx + 1'b1;
            end
            datarom_data = rom_mem[rom_idx];
            rand_word    = $random(seed);
            datarom_wait = rom_wait_rand && rand_word[0];
            if (!ob_wait_rand) begin
                ob_wait = 1'b0;
            end else begin
                if (span_left == 0) begin
                    rand_word  = $random(seed);
                    span_level = rand_word[0];
                    span_left  = int'(rand_word[4:2]) + 1;
                end
                ob_wait   = span_level;
                span_left = span_left - 1;
            end
        end
    end

    // Loads a stream, computes its words and pulses dcu_init
    task automatic start_stream(input logic [31:0] stream_seed, input int n_words);
        @(posedge CLK);
        fill_rom(stream_seed);
        decode_expected(n_words);
        #2;
        dcu_init = 1'b1;
        @(posedge CLK);
        #2;
        dcu_init = 1'b0;
    endtask

    task automatic collect_words(input int n_words);
        int waited;
        for (int k = 0; k < n_words; k++) begin
            waited = 0;
            @(negedge CLK);
            while (!ob_wr && waited < WORD_TIMEOUT) begin
                @(negedge CLK);
                waited = waited + 1;
            end
            assert (ob_wr) else
                stop_on_error($sformatf("Timed out waiting for output word %0d", k));
            assert (ob_data == expect_q[k]) else
                stop_on_error($sformatf("[ERROR] t=%0t ob_data expected %h actual %h",
                                        $time, expect_q[k], ob_data));
        end
    endtask

    task automatic check_quiet(input int cycles, input logic check_rd);
        for (int c = 0; c < cycles; c++) begin
            @(negedge CLK);
            assert (!(check_rd && datarom_rd)) else
                stop_on_error($sformatf("[ERROR] t=%0t datarom_rd expected 0 actual 1", $time));
            assert (!ob_wr) else
                stop_on_error($sformatf("[ERROR] t=%0t ob_wr expected 0 actual 1", $time));
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        dcu_init      = 1'b0;
        rom_wait_rand = 1'b0;
        ob_wait_rand  = 1'b0;
        repeat (16) @(posedge CLK);
        #2;
        rst_n = 1'b1;
        check_quiet(50, 1'b1);
        for (int r = 0; r < NUM_ROWS; r++) begin
            rom_wait_rand = STIM_TABLE[r].rom_rand;
            ob_wait_rand  = STIM_TABLE[r].ob_rand;
            // Part of an unrelated stream first, then restart
            if (STIM_TABLE[r].mid_init) begin
                start_stream(STIM_TABLE[r].seed ^ 32'h0000ffff, PARTIAL_WORDS);
                collect_words(PARTIAL_WORDS);
            end
            start_stream(STIM_TABLE[r].seed, int'(STIM_TABLE[r].words));
            collect_words(int'(STIM_TABLE[r].words));
            // Next word needs at least two cycles per bit, so none is due yet
            check_quiet(20, 1'b0);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule
